/* hdl/mapper_pkg.sv */
// shared register map, region count and field positions for the bus mapper and its testbench
`default_nettype none

package mapper_pkg;

    // region table
    localparam int NUM_REGIONS = 8;

    // register file geometry, index is addr[5:1]
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    // register indices
    localparam logic [REG_ADDR_W-1:0] REG_CTRL        = 5'd2;   // cpu reset / halt
    localparam logic [REG_ADDR_W-1:0] REG_SND         = 5'd3;   // latch toward sound cpu
    localparam logic [REG_ADDR_W-1:0] REG_IRQ         = 5'd4;   // interrupt level
    localparam logic [REG_ADDR_W-1:0] REG_DATA_HI     = 5'd13;  // readback word, high byte
    localparam logic [REG_ADDR_W-1:0] REG_DATA_LO     = 5'd14;  // readback word, low byte
    localparam logic [REG_ADDR_W-1:0] REG_REGION_BASE = 5'd16;  // ctrl at 16+2r, base at 16+2r+1

    // bits inside the control register
    localparam int CTRL_RST_BIT  = 0;
    localparam int CTRL_HALT_BIT = 1;

    // 2-bit fields inside a region control byte
    localparam int SIZE_LSB = 0;  // 64k/128k/512k/2048k
    localparam int WAIT_LSB = 2;  // extra dtack cycles

    // interrupt priority level codes on the active-low IPL lines
    localparam logic [2:0] IPL_IDLE = 3'b111;  // no request
    localparam logic [2:0] IPL_VBL  = 3'b011;  // level 4, vertical blank

endpackage

`default_nettype wire

/* hdl/region_cfg_if.sv */
// per-region base, size and wait codes, driven by the register block and read by matchers and arbiter
`timescale 1ns/1ps
`default_nettype none

interface region_cfg_if;

    logic [7:0] base      [mapper_pkg::NUM_REGIONS];  // upper address byte of each region
    logic [1:0] size      [mapper_pkg::NUM_REGIONS];  // size code, 0 = 64 kB
    logic [1:0] wait_code [mapper_pkg::NUM_REGIONS];  // dtack stretch code

    // register block owns the whole table
    modport regs (
        output base,
        output size,
        output wait_code
    );

    // address comparison only needs base and size
    modport match (
        input base,
        input size
    );

    // arbiter picks the wait code of the winner
    modport arb (
        input wait_code
    );

endinterface

`default_nettype wire

/* hdl/mapper_regs.sv */
// CPU-programmed register file of the mapper, drives region table, reset/halt, sound latch, readback
`timescale 1ns/1ps
`default_nettype none

module mapper_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic [5:1]  addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  cpu_dsn,
    input  logic        cpu_asn,
    input  logic        cpu_rnw,
    input  logic        none,
    input  logic        sndmap_rd,
    output logic        cpu_rst,
    output logic        cpu_haltn,
    output logic [7:0]  sndmap_dout,
    output logic        sndmap_pbf,
    output logic [15:0] mapper_dout,
    region_cfg_if.regs  cfg
);

    logic [7:0] mmr [mapper_pkg::REG_COUNT];
    logic       wren;
    logic       wren_l;
    logic       wredge;
    logic       rst_aux;

    // registers only answer where no region decodes
    assign wren   = ~cpu_asn & ~cpu_dsn[0] & ~cpu_rnw & none;
    assign wredge = wren & ~wren_l;  // one write per bus cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            wren_l <= 1'b0;
        end else begin
            wren_l <= wren;
        end
    end

    // byte writes from the low data lane
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mapper_pkg::REG_COUNT; i++) begin
                mmr[i] <= 8'd0;
            end
            mmr[mapper_pkg::REG_IRQ] <= {5'd0, mapper_pkg::IPL_IDLE};
        end else if (wredge) begin
            mmr[addr] <= cpu_dout[7:0];
        end
    end

    // buffer-full flag toward the sound cpu, a read from that side wins
    always_ff @(posedge clk) begin
        if (rst) begin
            sndmap_pbf <= 1'b0;
        end else begin
            if (wredge && addr == mapper_pkg::REG_SND) begin
                sndmap_pbf <= 1'b1;
            end
            if (sndmap_rd) begin
                sndmap_pbf <= 1'b0;
            end
        end
    end

    // two-stage cpu reset, rst itself holds both stages high
    always_ff @(posedge clk) begin
        rst_aux <= mmr[mapper_pkg::REG_CTRL][mapper_pkg::CTRL_RST_BIT] | rst;
        cpu_rst <= rst_aux;
    end

    assign cpu_haltn   = ~mmr[mapper_pkg::REG_CTRL][mapper_pkg::CTRL_HALT_BIT];
    assign sndmap_dout = mmr[mapper_pkg::REG_SND];
    assign mapper_dout = {mmr[mapper_pkg::REG_DATA_HI], mmr[mapper_pkg::REG_DATA_LO]};

    // region table: control byte then base byte per region
    always_comb begin
        for (int r = 0; r < mapper_pkg::NUM_REGIONS; r++) begin
            cfg.size[r]      = mmr[mapper_pkg::REG_REGION_BASE + 2*r][mapper_pkg::SIZE_LSB +: 2];
            cfg.wait_code[r] = mmr[mapper_pkg::REG_REGION_BASE + 2*r][mapper_pkg::WAIT_LSB +: 2];
            cfg.base[r]      = mmr[mapper_pkg::REG_REGION_BASE + 2*r + 1];
        end
    end

endmodule

`default_nettype wire

/* hdl/region_match.sv */
// address comparator for one mapped region, size code picks how many upper bits take part
`timescale 1ns/1ps
`default_nettype none

module region_match (
    input  logic [23:16] addr_hi,
    input  logic [7:0]   base,
    input  logic [1:0]   size,
    output logic         hit
);

    // larger regions ignore more of the low base bits
    always_comb begin
        case (size)
            2'd0:    hit = addr_hi[23:16] == base;       // 64 kB
            2'd1:    hit = addr_hi[23:17] == base[7:1];  // 128 kB
            2'd2:    hit = addr_hi[23:19] == base[7:3];  // 512 kB
            default: hit = addr_hi[23:21] == base[7:5];  // 2048 kB
        endcase
    end

endmodule

`default_nettype wire

/* hdl/region_arbiter.sv */
// fixed-priority pick among region hits plus wait-state stretched DTACK for the selected region
`timescale 1ns/1ps
`default_nettype none

module region_arbiter (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_cen,
    input  logic       cpu_asn,
    input  logic [2:0] cpu_fc,
    input  logic [7:0] hit,
    output logic [7:0] active,
    output logic       none,
    output logic       cpu_dtackn,
    region_cfg_if.arb  cfg
);

    logic [7:0] first_hit;
    logic [1:0] wait_sel;
    logic [2:0] dly;  // active-low dtack after 1, 2, 3 enabled edges

    // lowest index wins
    assign first_hit = hit & (~hit + 8'd1);

    always_comb begin
        if (&cpu_fc) begin
            active = 8'd0;  // interrupt acknowledge space
            none   = 1'b0;
        end else begin
            active = first_hit;
            none   = hit == 8'd0;
        end
    end

    // wait code of the one-hot winner, zero when nothing decodes
    always_comb begin
        wait_sel = 2'd0;
        for (int r = 0; r < mapper_pkg::NUM_REGIONS; r++) begin
            if (active[r]) begin
                wait_sel = cfg.wait_code[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dly <= 3'b111;
        end else if (cpu_asn) begin
            dly <= 3'b111;               // idle between bus cycles
        end else if (cpu_cen) begin
            dly <= {dly[1:0], 1'b0};
        end
    end

    always_comb begin
        case (wait_sel)
            2'd3:    cpu_dtackn = dly[2];
            2'd2:    cpu_dtackn = dly[1];
            default: cpu_dtackn = dly[0];  // codes 0 and 1 share the fast path
        endcase
    end

endmodule

`default_nettype wire

/* hdl/vblank_irq.sv */
// level-4 autovector interrupt from vertical blank, cleared by the CPU acknowledge cycle
`timescale 1ns/1ps
`default_nettype none

module vblank_irq (
    input  logic       clk,
    input  logic       rst,
    input  logic       vint,
    input  logic       cpu_asn,
    input  logic [2:0] cpu_fc,
    output logic [2:0] cpu_ipln,
    output logic       cpu_vpan
);

    logic last_vint;
    logic pending;
    logic inta;

    // function code 7 with strobe low is the acknowledge
    assign inta = ~cpu_asn & (&cpu_fc);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_vint <= 1'b0;
            pending   <= 1'b0;
        end else begin
            last_vint <= vint;
            if (inta) begin
                pending <= 1'b0;
            end else if (vint && !last_vint) begin
                pending <= 1'b1;  // rising edge only
            end
        end
    end

    assign cpu_ipln = pending ? mapper_pkg::IPL_VBL : mapper_pkg::IPL_IDLE;
    assign cpu_vpan = ~inta;  // cpu takes the autovector

endmodule

`default_nettype wire

/* hdl/bus_mapper_top.sv */
// top of the 68000 address mapper, joins registers, region matchers, arbiter and vblank interrupt
`timescale 1ns/1ps
`default_nettype none

module bus_mapper_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_cen,
    input  logic        vint,
    input  logic [23:1] addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  cpu_dsn,
    input  logic        cpu_asn,
    input  logic        cpu_rnw,
    input  logic [2:0]  cpu_fc,
    input  logic        sndmap_rd,
    output logic        cpu_rst,
    output logic        cpu_haltn,
    output logic        cpu_dtackn,
    output logic [2:0]  cpu_ipln,
    output logic        cpu_vpan,
    output logic [7:0]  active,
    output logic        none,
    output logic [15:0] mapper_dout,
    output logic [7:0]  sndmap_dout,
    output logic        sndmap_pbf
);

    logic [7:0] hit;  // one bit per matcher

    region_cfg_if cfg ();

    mapper_regs mapper_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .addr        (addr[5:1]),
        .cpu_dout    (cpu_dout),
        .cpu_dsn     (cpu_dsn),
        .cpu_asn     (cpu_asn),
        .cpu_rnw     (cpu_rnw),
        .none        (none),
        .sndmap_rd   (sndmap_rd),
        .cpu_rst     (cpu_rst),
        .cpu_haltn   (cpu_haltn),
        .sndmap_dout (sndmap_dout),
        .sndmap_pbf  (sndmap_pbf),
        .mapper_dout (mapper_dout),
        .cfg         (cfg.regs)
    );

    for (genvar g = 0; g < mapper_pkg::NUM_REGIONS; g++) begin : gen_match
        region_match region_match_inst (
            .addr_hi (addr[23:16]),
            .base    (cfg.base[g]),
            .size    (cfg.size[g]),
            .hit     (hit[g])
        );
    end

    region_arbiter region_arbiter_inst (
        .clk        (clk),
        .rst        (rst),
        .cpu_cen    (cpu_cen),
        .cpu_asn    (cpu_asn),
        .cpu_fc     (cpu_fc),
        .hit        (hit),
        .active     (active),
        .none       (none),
        .cpu_dtackn (cpu_dtackn),
        .cfg        (cfg.arb)
    );

    vblank_irq vblank_irq_inst (
        .clk      (clk),
        .rst      (rst),
        .vint     (vint),
        .cpu_asn  (cpu_asn),
        .cpu_fc   (cpu_fc),
        .cpu_ipln (cpu_ipln),
        .cpu_vpan (cpu_vpan)
    );

endmodule

`default_nettype wire

/* verification/bus_mapper_tb.sv */
// self-checking testbench for the bus mapper top level, built and run by run_sim.sh
`timescale 1ns/1ps
`default_nettype none

module bus_mapper_tb;

    localparam int WATCHDOG_CYCLES = 20000;  // a full run takes well under 1000 clocks
    localparam logic [2:0] FC_DATA = 3'b101;  // supervisor data space
    localparam logic [2:0] FC_IACK = 3'b111;

    logic        clk = 1'b0;
    logic        rst;
    logic        cpu_cen;
    logic        vint;
    logic [23:1] addr;
    logic [15:0] cpu_dout;
    logic [1:0]  cpu_dsn;
    logic        cpu_asn;
    logic        cpu_rnw;
    logic [2:0]  cpu_fc;
    logic        sndmap_rd;
    logic        cpu_rst;
    logic        cpu_haltn;
    logic        cpu_dtackn;
    logic [2:0]  cpu_ipln;
    logic        cpu_vpan;
    logic [7:0]  active;
    logic        none;
    logic [15:0] mapper_dout;
    logic [7:0]  sndmap_dout;
    logic        sndmap_pbf;

    // expected region table, follows every write that lands
    logic [7:0]  m_base [mapper_pkg::NUM_REGIONS];
    logic [1:0]  m_size [mapper_pkg::NUM_REGIONS];
    logic [15:0] lfsr_state;
    logic        cen_random;  // toggles cpu_cen during bus cycles
    logic        vpan_at_ack;
    int          pass_cnt;
    int          fail_cnt;
    int          test_fails;

    always #4 clk = ~clk;

    bus_mapper_top bus_mapper_top_inst (
        .clk         (clk),
        .rst         (rst),
        .cpu_cen     (cpu_cen),
        .vint        (vint),
        .addr        (addr),
        .cpu_dout    (cpu_dout),
        .cpu_dsn     (cpu_dsn),
        .cpu_asn     (cpu_asn),
        .cpu_rnw     (cpu_rnw),
        .cpu_fc      (cpu_fc),
        .sndmap_rd   (sndmap_rd),
        .cpu_rst     (cpu_rst),
        .cpu_haltn   (cpu_haltn),
        .cpu_dtackn  (cpu_dtackn),
        .cpu_ipln    (cpu_ipln),
        .cpu_vpan    (cpu_vpan),
        .active      (active),
        .none        (none),
        .mapper_dout (mapper_dout),
        .sndmap_dout (sndmap_dout),
        .sndmap_pbf  (sndmap_pbf)
    );

    // vector pull only during an acknowledge
    vpan_check: assert property (@(posedge clk) disable iff (rst)
        cpu_vpan == !(!cpu_asn && cpu_fc == FC_IACK))
    else begin
        $display("FAIL cpu_vpan: got %h with cpu_asn %h cpu_fc %h", cpu_vpan, cpu_asn, cpu_fc);
        fail_cnt++;
    end

    dtack_idle_check: assert property (@(posedge clk) disable iff (rst)
        $past(cpu_asn) |-> cpu_dtackn)
    else begin
        $display("FAIL cpu_dtackn: got %h one clock after cpu_asn high", cpu_dtackn);
        fail_cnt++;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [23:0] take_bits(input int n);
        logic [23:0] v;
        v = 24'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[22:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // {none, active} from the size masks, lowest region first
    function automatic logic [8:0] model_decode(input logic [7:0] hi);
        logic [7:0] mask;
        logic [8:0] res;
        res = {1'b1, 8'h00};
        for (int r = mapper_pkg::NUM_REGIONS - 1; r >= 0; r--) begin
            case (m_size[r])
                2'd0:    mask = 8'hff;
                2'd1:    mask = 8'hfe;
                2'd2:    mask = 8'hf8;
                default: mask = 8'he0;
            endcase
            if (((hi ^ m_base[r]) & mask) == 8'h00) begin
                res = {1'b0, 8'h01 << r};
            end
        end
        return res;
    endfunction

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) begin
            pass_cnt++;
        end else begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_cnt++;
        end
    endtask

    task automatic finish_test(input string name);
        if (fail_cnt == test_fails) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d failures", name, fail_cnt - test_fails);
        end
        test_fails = fail_cnt;
    endtask

    task automatic probe(input logic [23:0] a, input logic [2:0] fc);
        logic [8:0] dec;
        @(posedge clk);
        addr   <= a[23:1];
        cpu_fc <= fc;
        @(negedge clk);
        dec = model_decode(a[23:16]);
        if (fc == FC_IACK) begin
            dec = 9'd0;  // acknowledge space decodes nothing
        end
        check_val("active", {8'd0, active}, {8'd0, dec[7:0]});
        check_val("none", {15'd0, none}, {15'd0, dec[8]});
    endtask

    // one 68000 cycle, returns the enabled edges seen until dtack
    task automatic bus_cycle(input logic [23:0] a, input logic rnw, input logic [7:0] data,
                             input logic [2:0] fc, output int edges);
        logic [23:0] cen_bits;
        logic        seen;
        @(posedge clk);
        addr     <= a[23:1];
        cpu_rnw  <= rnw;
        cpu_dout <= {8'h00, data};
        cpu_dsn  <= 2'b00;
        cpu_fc   <= fc;
        cpu_asn  <= 1'b0;
        if (cen_random) begin
            cen_bits = take_bits(1);
            cpu_cen <= cen_bits[0];
        end
        edges = 0;
        seen  = 1'b0;
        for (int n = 0; n < 32 && !seen; n++) begin
            @(posedge clk);
            if (cpu_cen) begin
                edges++;
            end
            if (cen_random) begin
                cen_bits = take_bits(1);
                cpu_cen <= cen_bits[0];
            end
            @(negedge clk);
            if (!cpu_dtackn) begin
                seen        = 1'b1;
                vpan_at_ack = cpu_vpan;
            end
        end
        if (!seen) begin
            $display("dtack never came within 32 clocks at address %h", a);
            fail_cnt++;
        end
        @(posedge clk);
        cpu_asn <= 1'b1;
        cpu_dsn <= 2'b11;
        cpu_rnw <= 1'b1;
        cpu_fc  <= FC_DATA;
        cpu_cen <= 1'b1;
    endtask

    task automatic reg_write(input logic [7:0] hi, input logic [4:0] idx, input logic [7:0] data);
        logic [8:0] dec;
        int         edges;
        dec = model_decode(hi);
        bus_cycle({hi, 10'h000, idx, 1'b0}, 1'b0, data, FC_DATA, edges);
        if (dec[8] && idx >= mapper_pkg::REG_REGION_BASE) begin
            if (idx[0]) begin
                m_base[idx[3:1]] = data;
            end else begin
                m_size[idx[3:1]] = data[mapper_pkg::SIZE_LSB +: 2];
            end
        end
    endtask

    initial begin : main
        int          edges;
        logic [23:0] rnd;
        logic [23:0] sel;
        logic [7:0]  b;

        lfsr_state  = 16'd16637;
        pass_cnt    = 0;
        fail_cnt    = 0;
        test_fails  = 0;
        cen_random  = 1'b0;
        vpan_at_ack = 1'b1;
        for (int r = 0; r < mapper_pkg::NUM_REGIONS; r++) begin
            m_base[r] = 8'h00;
            m_size[r] = 2'd0;
        end
        rst       = 1'b1;
        cpu_cen   = 1'b1;
        vint      = 1'b0;
        addr      = 23'd0;
        cpu_dout  = 16'h0000;
        cpu_dsn   = 2'b11;
        cpu_asn   = 1'b1;
        cpu_rnw   = 1'b1;
        cpu_fc    = FC_DATA;
        sndmap_rd = 1'b0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("cpu_ipln", {13'd0, cpu_ipln}, 16'h0007);
        check_val("cpu_haltn", {15'd0, cpu_haltn}, 16'h0001);
        check_val("sndmap_pbf", {15'd0, sndmap_pbf}, 16'h0000);
        check_val("cpu_dtackn", {15'd0, cpu_dtackn}, 16'h0001);
        @(negedge clk);
        check_val("cpu_rst", {15'd0, cpu_rst}, 16'h0001);
        @(negedge clk);
        check_val("cpu_rst", {15'd0, cpu_rst}, 16'h0000);  // two clocks after rst fell
        probe(24'h000000, FC_DATA);
        probe(24'h5a0000, FC_DATA);
        finish_test("reset");

        for (int r = 0; r < mapper_pkg::NUM_REGIONS; r++) begin
            rnd = take_bits(12);
            b   = rnd[7:0];
            if (b[7:5] == 3'b111) begin
                b[7] = 1'b0;  // page 0xff stays free for register writes
            end
            reg_write(8'hff, 5'(16 + 2 * r), {4'h0, rnd[11:8]});
            reg_write(8'hff, 5'(17 + 2 * r), b);
        end
        for (int i = 0; i < 40; i++) begin
            rnd = take_bits(24);
            sel = take_bits(7);
            if (sel[6]) begin
                rnd[23:16] = m_base[sel[2:0]] ^ {5'd0, sel[5:3]};  // near a region
            end
            probe(rnd, (i % 8 == 7) ? FC_IACK : FC_DATA);
        end
        finish_test("regions");

        for (int wc = 0; wc < 4; wc++) begin
            reg_write(8'hff, mapper_pkg::REG_REGION_BASE, {4'h0, 2'(wc), m_size[0]});
            cen_random = 1'b1;
            bus_cycle({m_base[0], 16'h0100}, 1'b1, 8'h00, FC_DATA, edges);
            cen_random = 1'b0;
            check_val("cpu_dtackn latency", 16'(edges), (wc < 2) ? 16'd1 : 16'(wc));
            @(negedge clk);
            check_val("cpu_dtackn", {15'd0, cpu_dtackn}, 16'h0000);
            @(negedge clk);
            check_val("cpu_dtackn", {15'd0, cpu_dtackn}, 16'h0001);
        end
        finish_test("dtack");

        rnd = take_bits(8);
        b   = rnd[7:0];
        reg_write(8'hff, mapper_pkg::REG_SND, b);
        @(negedge clk);
        check_val("sndmap_dout", {8'd0, sndmap_dout}, {8'd0, b});
        check_val("sndmap_pbf", {15'd0, sndmap_pbf}, 16'h0001);
        @(posedge clk);
        sndmap_rd <= 1'b1;
        @(posedge clk);
        sndmap_rd <= 1'b0;
        @(negedge clk);
        check_val("sndmap_pbf", {15'd0, sndmap_pbf}, 16'h0000);
        reg_write(m_base[0], mapper_pkg::REG_SND, ~b);  // region 0 owns this page
        @(negedge clk);
        check_val("sndmap_dout", {8'd0, sndmap_dout}, {8'd0, b});
        check_val("sndmap_pbf", {15'd0, sndmap_pbf}, 16'h0000);
        finish_test("sound");

        @(posedge clk);
        vint <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_val("cpu_ipln", {13'd0, cpu_ipln}, 16'h0003);
        @(posedge clk);
        vint <= 1'b0;
        bus_cycle(24'hfffff8, 1'b1, 8'h00, FC_IACK, edges);
        check_val("cpu_vpan", {15'd0, vpan_at_ack}, 16'h0000);
        @(negedge clk);
        check_val("cpu_ipln", {13'd0, cpu_ipln}, 16'h0007);
        finish_test("interrupt");

        reg_write(8'hff, mapper_pkg::REG_CTRL, 8'h02);
        @(negedge clk);
        check_val("cpu_haltn", {15'd0, cpu_haltn}, 16'h0000);
        reg_write(8'hff, mapper_pkg::REG_CTRL, 8'h03);
        @(negedge clk);
        check_val("cpu_rst", {15'd0, cpu_rst}, 16'h0000);
        @(negedge clk);
        check_val("cpu_rst", {15'd0, cpu_rst}, 16'h0001);
        reg_write(8'hff, mapper_pkg::REG_CTRL, 8'h00);
        rnd = take_bits(16);
        reg_write(8'hff, mapper_pkg::REG_DATA_HI, rnd[15:8]);
        reg_write(8'hff, mapper_pkg::REG_DATA_LO, rnd[7:0]);
        @(negedge clk);
        check_val("mapper_dout", mapper_dout, rnd[15:0]);
        check_val("cpu_haltn", {15'd0, cpu_haltn}, 16'h0001);
        finish_test("control");

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not complete within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hdl/mapper_pkg.sv
hdl/region_cfg_if.sv
hdl/mapper_regs.sv
hdl/region_match.sv
hdl/region_arbiter.sv
hdl/vblank_irq.sv
hdl/bus_mapper_top.sv
verification/bus_mapper_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the bus mapper testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module bus_mapper_tb \
    -f files.f \
    --Mdir obj_dir \
    -o bus_mapper_sim

./obj_dir/bus_mapper_sim | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
